// ==== flist.f ====
+incdir+include
verilog/csr_pkg.sv
verilog/axi_lite_write.sv
verilog/axi_lite_slave.sv
verilog/csr_regfile.sv
verilog/aes_dma_csr_top.sv
sim/tb_aes_dma_csr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AES DMA CSR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_aes_dma_csr -f flist.f

output=$(./obj_dir/Vtb_aes_dma_csr)
echo "$output"

if echo "$output" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1

// ==== sim/tb_aes_dma_csr.sv ====
// ==============================
// AES DMA CSR testbench
// ==============================
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module tb_aes_dma_csr;

   import csr_pkg::*;

   // 200 accesses at up to 12 cycles each plus reset
   localparam int RESET_CYCLES = 16;
   localparam int CYCLE_LIMIT  = RESET_CYCLES + 200 * 12;
   localparam int HS_LIMIT     = 16;
   // Handshake signals watched by wait_level
   localparam int CH_AW = 0;
   localparam int CH_W  = 1;
   localparam int CH_B  = 2;
   localparam int CH_AR = 3;
   localparam int CH_R  = 4;

   logic                   clk;
   logic                   reset;
   logic                   awvalid_i;
   logic                   awready_o;
   logic [`CSR_ADDR_W-1:0] awaddr_i;
   logic                   wvalid_i;
   logic                   wready_o;
   logic [`CSR_DATA_W-1:0] wdata_i;
   logic                   bvalid_o;
   logic                   bready_i;
   axi_resp_t              bresp_o;
   logic                   arvalid_i;
   logic                   arready_o;
   logic [`CSR_ADDR_W-1:0] araddr_i;
   logic                   rvalid_o;
   logic                   rready_i;
   logic [`CSR_DATA_W-1:0] rdata_o;
   axi_resp_t              rresp_o;
   logic [`CSR_DATA_W-1:0] aes_sts_dbg_i;
   logic                   mm2s_intr_i;
   logic                   s2mm_intr_i;
   logic                   axi_intr_o;

   integer      seed;
   int          errors = 0;
   int          checks = 0;
   int          mark = 0;
   int          cycle_count = 0;
   int          b_count = 0;
   int          r_count = 0;
   int          ar_count = 0;
   int          wr_strobes = 0;
   int          writes_issued = 0;
   int          reads_issued = 0;
   int          ar_mark;
   int          i;
   int          k;
   // Reference model state
   logic [31:0] m_scratch;
   csr_ctrl_u   m_ctrl;
   logic        m_mm2s;
   logic        m_s2mm;
   logic [31:0] dbg_word;
   logic [31:0] word;

   aes_dma_csr_top dut0 (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Handshake counters and watchdog
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (bvalid_o && bready_i)
         b_count <= b_count + 1;
      if (rvalid_o && rready_i)
         r_count <= r_count + 1;
      if (arvalid_i && arready_o)
         ar_count <= ar_count + 1;
      // Register file write strobes
      if (dut0.reg_wr)
         wr_strobes <= wr_strobes + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Run stopped at the cycle limit of %0d before all tests ended", CYCLE_LIMIT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   function automatic logic level_of(input int ch);
      case (ch)
         CH_AW:   return awready_o;
         CH_W:    return wready_o;
         CH_B:    return bvalid_o;
         CH_AR:   return arready_o;
         default: return rvalid_o;
      endcase
   endfunction

   // Expected read data per the register map
   function automatic logic [31:0] model_read(input int idx);
      case (idx)
         `CSR_IDX_MM2S:    return {31'd0, m_mm2s};
         `CSR_IDX_S2MM:    return {31'd0, m_s2mm};
         `CSR_IDX_CTRL:    return m_ctrl.raw;
         `CSR_IDX_SCRATCH: return m_scratch;
         `CSR_IDX_AES_DBG: return dbg_word;
         `CSR_IDX_ID:      return 32'hDEAD_BEEF;
         default:          return (idx < 14) ? 32'(idx) : 32'd0;
      endcase
   endfunction

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checks = checks + 1;
      if (got !== exp)
      begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         errors = errors + 1;
      end
   endtask

   // Poll on falling edges until the signal rises
   task automatic wait_level(input int ch, input string what);
      int n;
      n = 0;
      while (!level_of(ch) && n < HS_LIMIT)
      begin
         @(negedge clk);
         n = n + 1;
      end
      if (!level_of(ch))
      begin
         $display("Handshake stuck: %s never went high", what);
         errors = errors + 1;
      end
   endtask

   // Called right after a falling edge and returns after one
   task automatic write_word(input int idx, input logic [31:0] data);
      int delay;
      delay = $unsigned($random(seed)) % 4;
      awvalid_i = 1'b1;
      awaddr_i  = 10'(idx * 4);
      wvalid_i  = 1'b1;
      wdata_i   = data;
      wait_level(CH_AW, "awready");
      @(negedge clk);
      awvalid_i = 1'b0;
      // Ready lines are single-cycle pulses
      check_word("awready", awready_o, 0);
      wait_level(CH_W, "wready");
      @(negedge clk);
      wvalid_i = 1'b0;
      check_word("wready", wready_o, 0);
      wait_level(CH_B, "bvalid");
      check_word("bresp", bresp_o, OKAY);
      // Response must hold under back-pressure
      repeat (delay)
      begin
         @(negedge clk);
         check_word("bvalid", bvalid_o, 1);
         check_word("bresp", bresp_o, OKAY);
      end
      bready_i = 1'b1;
      @(negedge clk);
      bready_i = 1'b0;
      check_word("bvalid", bvalid_o, 0);
      writes_issued = writes_issued + 1;
      // Model update
      if (idx == `CSR_IDX_CTRL)
         m_ctrl.raw = data;
      if (idx == `CSR_IDX_SCRATCH)
         m_scratch = data;
      if (idx == `CSR_IDX_MM2S && data[0])
         m_mm2s = 1'b0;
      if (idx == `CSR_IDX_S2MM && data[0])
         m_s2mm = 1'b0;
   endtask

   task automatic read_compare(input int idx);
      int          delay;
      logic [31:0] held;
      delay = $unsigned($random(seed)) % 4;
      arvalid_i = 1'b1;
      araddr_i  = 10'(idx * 4);
      wait_level(CH_AR, "arready");
      @(negedge clk);
      arvalid_i = 1'b0;
      check_word("arready", arready_o, 0);
      wait_level(CH_R, "rvalid");
      held = rdata_o;
      check_word("rresp", rresp_o, OKAY);
      repeat (delay)
      begin
         @(negedge clk);
         check_word("rvalid", rvalid_o, 1);
         check_word("rdata", rdata_o, held);
         check_word("rresp", rresp_o, OKAY);
      end
      rready_i = 1'b1;
      @(negedge clk);
      rready_i = 1'b0;
      check_word("rvalid", rvalid_o, 0);
      reads_issued = reads_issued + 1;
      check_word("rdata", held, model_read(idx));
   endtask

   // One-cycle interrupt pulses with bit 0 MM2S and bit 1 S2MM
   task automatic pulse_intr(input logic [1:0] which);
      mm2s_intr_i = which[0];
      s2mm_intr_i = which[1];
      @(negedge clk);
      mm2s_intr_i = 1'b0;
      s2mm_intr_i = 1'b0;
      m_mm2s = m_mm2s | which[0];
      m_s2mm = m_s2mm | which[1];
   endtask

   // Registered output settles within two cycles
   task automatic check_intr();
      repeat (2) @(negedge clk);
      check_word("axi_intr_o", axi_intr_o,
                 (m_mm2s & m_ctrl.fields.mm2s_ie) | (m_s2mm & m_ctrl.fields.s2mm_ie));
   endtask

   task automatic report_test(input string name);
      $display("Test %s finished with %0d errors", name, errors - mark);
      mark = errors;
   endtask

   initial
   begin
      seed = 38;
      reset = 1'b1;
      awvalid_i = 1'b0;
      awaddr_i = '0;
      wvalid_i = 1'b0;
      wdata_i = '0;
      bready_i = 1'b0;
      arvalid_i = 1'b0;
      araddr_i = '0;
      rready_i = 1'b0;
      aes_sts_dbg_i = '0;
      mm2s_intr_i = 1'b0;
      s2mm_intr_i = 1'b0;
      m_scratch = '0;
      m_ctrl.raw = '0;
      m_mm2s = 1'b0;
      m_s2mm = 1'b0;
      dbg_word = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // Reset values, index echo, ID word and an index above 15
      for (k = 2; k < 14; k++)
         read_compare(k);
      read_compare(`CSR_IDX_ID);
      read_compare(20);
      report_test("reset_values");

      for (i = 0; i < 16; i++)
      begin
         write_word(`CSR_IDX_SCRATCH, $random(seed));
         write_word(`CSR_IDX_CTRL, $random(seed));
         read_compare(`CSR_IDX_SCRATCH);
         read_compare(`CSR_IDX_CTRL);
      end
      report_test("scratch_ctrl_rw");

      // Sticky set then write-1-to-clear
      for (i = 0; i < 6; i++)
      begin
         pulse_intr(2'($random(seed)));
         read_compare(`CSR_IDX_MM2S);
         read_compare(`CSR_IDX_S2MM);
         word = $random(seed);
         word[0] = 1'b1;
         write_word($unsigned($random(seed)) % 2, word);
         read_compare(`CSR_IDX_MM2S);
         read_compare(`CSR_IDX_S2MM);
      end
      report_test("sticky_status");

      for (i = 0; i < 8; i++)
      begin
         write_word(`CSR_IDX_CTRL, $random(seed));
         check_intr();
         pulse_intr(2'($random(seed)));
         check_intr();
         write_word($unsigned($random(seed)) % 2, 32'd1);
         check_intr();
      end
      report_test("interrupt_out");

      for (i = 0; i < 8; i++)
      begin
         dbg_word = $random(seed);
         aes_sts_dbg_i = dbg_word;
         read_compare(`CSR_IDX_AES_DBG);
      end
      report_test("aes_debug");

      // Read raised together with a write that must finish first
      for (i = 0; i < 8; i++)
      begin
         ar_mark = ar_count;
         arvalid_i = 1'b1;
         araddr_i = 10'(`CSR_IDX_SCRATCH * 4);
         write_word(`CSR_IDX_SCRATCH, $random(seed));
         if (ar_count != ar_mark)
         begin
            $display("Read address was accepted before the write response");
            errors = errors + 1;
         end
         read_compare(`CSR_IDX_SCRATCH);
      end
      // Each access completed exactly once
      check_word("bvalid handshakes", b_count, writes_issued);
      check_word("rvalid handshakes", r_count, reads_issued);
      check_word("reg_wr strobes", wr_strobes, writes_issued);
      report_test("write_before_read");

      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/aes_dma_csr_top.sv ====
// ==============================
// AES DMA CSR top level
// ==============================
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module aes_dma_csr_top
(
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    awvalid_i,
   output logic                   awready_o,
   input  wire [`CSR_ADDR_W-1:0]  awaddr_i,
   input  wire                    wvalid_i,
   output logic                   wready_o,
   input  wire [`CSR_DATA_W-1:0]  wdata_i,
   output logic                   bvalid_o,
   input  wire                    bready_i,
   output csr_pkg::axi_resp_t     bresp_o,
   input  wire                    arvalid_i,
   output logic                   arready_o,
   input  wire [`CSR_ADDR_W-1:0]  araddr_i,
   output logic                   rvalid_o,
   input  wire                    rready_i,
   output logic [`CSR_DATA_W-1:0] rdata_o,
   output csr_pkg::axi_resp_t     rresp_o,
   // Engine status and DMA interrupts
   input  wire [`CSR_DATA_W-1:0]  aes_sts_dbg_i,
   input  wire                    mm2s_intr_i,
   input  wire                    s2mm_intr_i,
   output logic                   axi_intr_o
);

   // Slave to register file
   logic                   reg_wr;
   logic [`CSR_ADDR_W-1:0] reg_addr;
   logic [`CSR_DATA_W-1:0] reg_wdata;
   logic [`CSR_ADDR_W-1:0] rd_addr;
   logic [`CSR_DATA_W-1:0] rd_data;

   axi_lite_slave u_slave
   (
      .clk         (clk),
      .reset       (reset),
      .awvalid_i   (awvalid_i),
      .awready_o   (awready_o),
      .awaddr_i    (awaddr_i),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .wdata_i     (wdata_i),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .bresp_o     (bresp_o),
      .arvalid_i   (arvalid_i),
      .arready_o   (arready_o),
      .araddr_i    (araddr_i),
      .rvalid_o    (rvalid_o),
      .rready_i    (rready_i),
      .rdata_o     (rdata_o),
      .rresp_o     (rresp_o),
      .reg_wr_o    (reg_wr),
      .reg_addr_o  (reg_addr),
      .reg_wdata_o (reg_wdata),
      .rd_addr_o   (rd_addr),
      .rd_data_i   (rd_data)
   );

   csr_regfile u_regfile
   (
      .clk           (clk),
      .reset         (reset),
      .reg_wr_i      (reg_wr),
      .reg_addr_i    (reg_addr),
      .reg_wdata_i   (reg_wdata),
      .rd_addr_i     (rd_addr),
      .rd_data_o     (rd_data),
      .aes_sts_dbg_i (aes_sts_dbg_i),
      .mm2s_intr_i   (mm2s_intr_i),
      .s2mm_intr_i   (s2mm_intr_i),
      .axi_intr_o    (axi_intr_o)
   );

endmodule

`default_nettype wire

// ==== verilog/csr_regfile.sv ====
// ==============================
// CSR register file
// ==============================
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_regfile
(
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    reg_wr_i,
   input  wire [`CSR_ADDR_W-1:0]  reg_addr_i,
   input  wire [`CSR_DATA_W-1:0]  reg_wdata_i,
   input  wire [`CSR_ADDR_W-1:0]  rd_addr_i,
   output logic [`CSR_DATA_W-1:0] rd_data_o,
   input  wire [`CSR_DATA_W-1:0]  aes_sts_dbg_i,
   input  wire                    mm2s_intr_i,
   input  wire                    s2mm_intr_i,
   output logic                   axi_intr_o
);

   import csr_pkg::*;

   logic [4:0]             wr_idx;
   logic [4:0]             rd_idx;
   logic                   mm2s_sts;
   logic                   s2mm_sts;
   logic                   mm2s_clr;
   logic                   s2mm_clr;
   csr_ctrl_u              ctrl_q;
   logic [`CSR_DATA_W-1:0] scratch_q;

   // Word index from address bits 6:2
   assign wr_idx = reg_addr_i[6:2];
   assign rd_idx = rd_addr_i[6:2];

   // Write-1-to-clear on bit 0
   assign mm2s_clr = reg_wr_i & (wr_idx == `CSR_IDX_MM2S) & reg_wdata_i[0];
   assign s2mm_clr = reg_wr_i & (wr_idx == `CSR_IDX_S2MM) & reg_wdata_i[0];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mm2s_sts   <= 1'b0;
         s2mm_sts   <= 1'b0;
         ctrl_q.raw <= '0;
         scratch_q  <= '0;
         axi_intr_o <= 1'b0;
      end
      else
      begin
         // Sticky status, a set beats a clear
         mm2s_sts <= mm2s_intr_i | (mm2s_sts & ~mm2s_clr);
         s2mm_sts <= s2mm_intr_i | (s2mm_sts & ~s2mm_clr);
         if (reg_wr_i & (wr_idx == `CSR_IDX_CTRL))
            ctrl_q.raw <= reg_wdata_i;
         if (reg_wr_i & (wr_idx == `CSR_IDX_SCRATCH))
            scratch_q <= reg_wdata_i;
         // Enabled status bits combined into one line
         axi_intr_o <= (mm2s_sts & ctrl_q.fields.mm2s_ie) |
                       (s2mm_sts & ctrl_q.fields.s2mm_ie);
      end
   end

   // Read mux
   always_comb
   begin
      case (rd_idx)
         `CSR_IDX_MM2S:    rd_data_o = {{(`CSR_DATA_W-1){1'b0}}, mm2s_sts};
         `CSR_IDX_S2MM:    rd_data_o = {{(`CSR_DATA_W-1){1'b0}}, s2mm_sts};
         `CSR_IDX_CTRL:    rd_data_o = ctrl_q.raw;
         `CSR_IDX_SCRATCH: rd_data_o = scratch_q;
         `CSR_IDX_AES_DBG: rd_data_o = aes_sts_dbg_i;
         `CSR_IDX_ID:      rd_data_o = `CSR_ID_WORD;
         default:
         begin
            // Indices 4 to 13 echo themselves, above 15 reads zero
            if (rd_idx[4] == 1'b0)
               rd_data_o = {{(`CSR_DATA_W-5){1'b0}}, rd_idx};
            else
               rd_data_o = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/axi_lite_slave.sv ====
// ==============================
// AXI-Lite slave front end
// ==============================
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module axi_lite_slave
(
   input  wire                    clk,
   input  wire                    reset,
   // Write address channel
   input  wire                    awvalid_i,
   output logic                   awready_o,
   input  wire [`CSR_ADDR_W-1:0]  awaddr_i,
   // Write data channel
   input  wire                    wvalid_i,
   output logic                   wready_o,
   input  wire [`CSR_DATA_W-1:0]  wdata_i,
   // Write response channel
   output logic                   bvalid_o,
   input  wire                    bready_i,
   output csr_pkg::axi_resp_t     bresp_o,
   // Read address channel
   input  wire                    arvalid_i,
   output logic                   arready_o,
   input  wire [`CSR_ADDR_W-1:0]  araddr_i,
   // Read data channel
   output logic                   rvalid_o,
   input  wire                    rready_i,
   output logic [`CSR_DATA_W-1:0] rdata_o,
   output csr_pkg::axi_resp_t     rresp_o,
   // Register file side
   output logic                   reg_wr_o,
   output logic [`CSR_ADDR_W-1:0] reg_addr_o,
   output logic [`CSR_DATA_W-1:0] reg_wdata_o,
   output logic [`CSR_ADDR_W-1:0] rd_addr_o,
   input  wire [`CSR_DATA_W-1:0]  rd_data_i
);

   import csr_pkg::*;

   logic aw_hs;
   logic ar_hs;
   logic b_hs;
   logic r_hs;
   logic wr_pending;
   logic rd_pending;
   logic idle;

   assign aw_hs = awvalid_i & awready_o;
   assign ar_hs = arvalid_i & arready_o;
   assign b_hs  = bvalid_o & bready_i;
   assign r_hs  = rvalid_o & rready_i;

   // Nothing in flight
   assign idle = ~wr_pending & ~rd_pending;

   // Pending flags, cleared by the response handshake
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_pending <= 1'b0;
         rd_pending <= 1'b0;
      end
      else
      begin
         wr_pending <= (aw_hs | wr_pending) & ~b_hs;
         rd_pending <= (ar_hs | rd_pending) & ~r_hs;
      end
   end

   // Ready pulses
   // awvalid blocks arready so a write goes first
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         awready_o <= 1'b0;
         arready_o <= 1'b0;
      end
      else
      begin
         awready_o <= awvalid_i & idle & ~awready_o;
         arready_o <= arvalid_i & idle & ~awvalid_i & ~arready_o;
      end
   end

   // Read address latch
   always_ff @(posedge clk)
   begin
      if (ar_hs)
         rd_addr_o <= araddr_i;
   end

   // Read response
   // Loaded once per read, stable until rready
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rvalid_o <= 1'b0;
      end
      else if (rd_pending & ~rvalid_o)
      begin
         rvalid_o <= 1'b1;
      end
      else if (r_hs)
      begin
         rvalid_o <= 1'b0;
      end
   end

   // Read payload
   always_ff @(posedge clk)
   begin
      if (rd_pending & ~rvalid_o)
      begin
         rdata_o <= rd_data_i;
         rresp_o <= OKAY;
      end
   end

   // Write data and response path
   axi_lite_write u_write
   (
      .clk         (clk),
      .reset       (reset),
      .awvalid_i   (awvalid_i),
      .awready_i   (awready_o),
      .awaddr_i    (awaddr_i),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .wdata_i     (wdata_i),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .bresp_o     (bresp_o),
      .reg_wr_o    (reg_wr_o),
      .reg_addr_o  (reg_addr_o),
      .reg_wdata_o (reg_wdata_o)
   );

endmodule

`default_nettype wire

// ==== verilog/axi_lite_write.sv ====
// ==============================
// AXI-Lite write path
// ==============================
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module axi_lite_write
(
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    awvalid_i,
   input  wire                    awready_i,
   input  wire [`CSR_ADDR_W-1:0]  awaddr_i,
   input  wire                    wvalid_i,
   output logic                   wready_o,
   input  wire [`CSR_DATA_W-1:0]  wdata_i,
   output logic                   bvalid_o,
   input  wire                    bready_i,
   output csr_pkg::axi_resp_t     bresp_o,
   output logic                   reg_wr_o,
   output logic [`CSR_ADDR_W-1:0] reg_addr_o,
   output logic [`CSR_DATA_W-1:0] reg_wdata_o
);

   import csr_pkg::*;

   // FSM encoding
   localparam logic [1:0] ST_ADDR = 2'd0;
   localparam logic [1:0] ST_DATA = 2'd1;
   localparam logic [1:0] ST_RESP = 2'd2;

   logic [1:0] state_q;
   logic       aw_hs;
   logic       w_hs;
   logic       b_hs;

   // Channel handshakes
   assign aw_hs = awvalid_i & awready_i;
   assign w_hs  = wvalid_i & wready_o;
   assign b_hs  = bvalid_o & bready_i;

   // Every write is answered OKAY
   assign bresp_o = OKAY;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_q  <= ST_ADDR;
         wready_o <= 1'b0;
         bvalid_o <= 1'b0;
         reg_wr_o <= 1'b0;
      end
      else
      begin
         // Strobe lasts a single cycle
         reg_wr_o <= 1'b0;
         case (state_q)
            ST_ADDR:
            begin
               // Address accepted by the slave's awready pulse
               if (aw_hs)
                  state_q <= ST_DATA;
            end
            ST_DATA:
            begin
               // One-cycle wready once data shows up
               wready_o <= wvalid_i & ~wready_o;
               if (w_hs)
               begin
                  reg_wr_o <= 1'b1;
                  bvalid_o <= 1'b1;
                  state_q  <= ST_RESP;
               end
            end
            ST_RESP:
            begin
               // Hold bvalid until the master takes it
               if (b_hs)
               begin
                  bvalid_o <= 1'b0;
                  state_q  <= ST_ADDR;
               end
            end
            default:
            begin
               state_q <= ST_ADDR;
            end
         endcase
      end
   end

   // Address and data payload
   always_ff @(posedge clk)
   begin
      if (aw_hs)
         reg_addr_o <= awaddr_i;
      if (w_hs)
         reg_wdata_o <= wdata_i;
   end

endmodule

`default_nettype wire

// ==== verilog/csr_pkg.sv ====
// ==============================
// CSR shared types
// ==============================
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

   // AXI response codes
   // Only OKAY is ever returned by this block
   typedef enum logic [1:0]
   {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_t;

   // Control word
   // Raw view for bus access, field view for interrupt gating
   typedef union packed
   {
      logic [`CSR_DATA_W-1:0] raw;
      struct packed
      {
         // Stored and read back, no function
         logic [`CSR_DATA_W-3:0] reserved;
         // S2MM interrupt enable
         logic                   s2mm_ie;
         // MM2S interrupt enable
         logic                   mm2s_ie;
      } fields;
   } csr_ctrl_u;

endpackage

`default_nettype wire

// ==== include/csr_macros.svh ====
// ==============================
// CSR widths and register map
// ==============================
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Bus widths
`define CSR_ADDR_W 10
`define CSR_DATA_W 32

// Word indices, decoded from address bits 6:2
`define CSR_IDX_MM2S    0
`define CSR_IDX_S2MM    1
`define CSR_IDX_CTRL    2
`define CSR_IDX_SCRATCH 3
`define CSR_IDX_AES_DBG 14
`define CSR_IDX_ID      15

// Fixed identification word
`define CSR_ID_WORD 32'hDEAD_BEEF

`endif
